// ==== periph_system.f ====
verilog/soc_pkg.sv
verilog/wb_decoder.sv
verilog/wb_bram.sv
verilog/wb_timer.sv
verilog/wb_pwm.sv
verilog/periph_system.sv
testbench/tb_periph_system.sv

// ==== testbench/tb_periph_system.sv ====
//--------------------
// Testbench for the peripheral subsystem
// Bus tasks, reference models, compare tasks
// Tests for RAM, unmapped space, timer and PWM
//--------------------

module tb_periph_system import soc_pkg::*; ();

	localparam int BRAM_ADR_W   = 10;
	localparam int PWM_CHANNELS = 8;
	localparam int RAM_WRITES   = 200;
	// Several times the whole test sequence
	localparam int MAX_CYCLES   = 20000;

	logic                    clk_i;
	logic                    reset_i;
	logic [ADR_W-1:0]        wb_adr_i;
	logic [DAT_W-1:0]        wb_dat_i;
	logic [SEL_W-1:0]        wb_sel_i;
	logic                    wb_we_i;
	logic                    wb_cyc_i;
	logic                    wb_stb_i;
	logic [DAT_W-1:0]        wb_dat_o;
	logic                    wb_ack_o;
	logic [1:0]              irq_o;
	logic [PWM_CHANNELS-1:0] pwm_o;

	int cycles;

	// RAM model keyed by word index, plus every address written
	logic [DAT_W-1:0] ram_model [int];
	logic [ADR_W-1:0] written_q [$];

	periph_system #(
		.BRAM_ADR_W   (BRAM_ADR_W),
		.PWM_CHANNELS (PWM_CHANNELS)
	) dut_i (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_sel_i (wb_sel_i),
		.wb_we_i  (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.irq_o    (irq_o),
		.pwm_o    (pwm_o)
	);

	// Clock, period 40
	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	// Watchdog
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("** FAIL **");
		$fatal(1, "timeout");
	end

	//--------------------
	// Reference models
	//--------------------
	function automatic logic [DAT_W-1:0] merge_bytes(input logic [DAT_W-1:0] old_word,
		input logic [DAT_W-1:0] new_word, input logic [SEL_W-1:0] sel);
		logic [DAT_W-1:0] res;
		res = old_word;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_word[8*b +: 8];
		end
		return res;
	endfunction

	// Word index, wraps at the RAM depth
	function automatic int ram_index(input logic [ADR_W-1:0] adr);
		return (adr >> 2) % (1 << BRAM_ADR_W);
	endfunction

	// High cycles per period, duty saturates at the period
	function automatic int pwm_high_count(input int duty, input int period);
		if (period == 0)
			return 0;
		return (duty < period) ? duty : period;
	endfunction

	function automatic logic [DAT_W-1:0] ctrl_word(input logic en, input logic auto_mode,
		input logic flag);
		logic [DAT_W-1:0] w;
		w = '0;
		w[CTRL_EN]   = en;
		w[CTRL_AUTO] = auto_mode;
		w[CTRL_FLAG] = flag;
		return w;
	endfunction

	function automatic logic [ADR_W-1:0] timer_adr(input logic ch, input timer_reg_e idx);
		return {REGION_TIMER, 23'd0, ch, idx, 2'b00};
	endfunction

	function automatic logic [ADR_W-1:0] pwm_adr(input int word);
		return {REGION_PWM, 28'd0} + 32'(word * 4);
	endfunction

	//--------------------
	// Compare tasks
	//--------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "check failed");
	endtask

	task automatic check_data(input string name, input logic [DAT_W-1:0] got,
		input logic [DAT_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
	endtask

	task automatic check_irq(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
	endtask

	task automatic check_pwm(input string name, input logic [PWM_CHANNELS-1:0] got,
		input logic [PWM_CHANNELS-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
	endtask

	//--------------------
	// Bus tasks
	//--------------------
	task automatic bus_cycle(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat,
		input logic [SEL_W-1:0] sel, input logic we, output logic [DAT_W-1:0] rdat);
		int waited;
		@(posedge clk_i);
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		wb_sel_i <= sel;
		wb_we_i  <= we;
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		// Ack sampled between edges
		waited = 0;
		do begin
			@(negedge clk_i);
			waited++;
		end while (!wb_ack_o);
		// Ack belongs one edge after the request edge
		if (waited != 2)
			fail_run($sformatf("Ack for address 0x%h arrived late, at falling edge %0d",
				adr, waited));
		rdat = wb_dat_o;
		@(posedge clk_i);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat,
		input logic [SEL_W-1:0] sel);
		logic [DAT_W-1:0] unused;
		bus_cycle(adr, dat, sel, 1'b1, unused);
	endtask

	task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DAT_W-1:0] dat);
		bus_cycle(adr, '0, '1, 1'b0, dat);
	endtask

	task automatic wait_irq(input int ch, input int limit);
		int waited;
		waited = 0;
		do begin
			@(negedge clk_i);
			waited++;
			if (waited > limit)
				fail_run($sformatf("Timer channel %0d raised no interrupt in %0d cycles",
					ch, limit));
		end while (!irq_o[ch]);
	endtask

	//--------------------
	// Tests
	//--------------------
	task automatic reset_values();
		logic [DAT_W-1:0] rd;
		@(negedge clk_i);
		check_data("wb_ack_o", {31'd0, wb_ack_o}, '0);
		check_irq("irq_o", irq_o, 2'b00);
		check_pwm("pwm_o", pwm_o, '0);
		for (int ch = 0; ch < 2; ch++) begin
			for (int i = 0; i < 3; i++) begin
				wb_read(timer_adr(ch[0], timer_reg_e'(i)), rd);
				check_data($sformatf("wb_dat_o timer ch%0d word %0d", ch, i), rd, '0);
			end
		end
		for (int w = 0; w <= PWM_CHANNELS; w++) begin
			wb_read(pwm_adr(w), rd);
			check_data($sformatf("wb_dat_o pwm word %0d", w), rd, '0);
		end
	endtask

	task automatic ram_random();
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] dat;
		logic [DAT_W-1:0] rd;
		logic [SEL_W-1:0] sel;
		int               idx;
		repeat (RAM_WRITES) begin
			// Anywhere in the region, high bits alias onto the depth
			adr = {REGION_BRAM, 28'($urandom)} & ~32'h3;
			dat = $urandom;
			sel = 4'($urandom);
			idx = ram_index(adr);
			if (ram_model.exists(idx)) begin
				ram_model[idx] = merge_bytes(ram_model[idx], dat, sel);
			end else begin
				// First write of a word fills every lane
				sel = '1;
				ram_model[idx] = dat;
			end
			wb_write(adr, dat, sel);
			written_q.push_back(adr);
		end
		foreach (written_q[i]) begin
			wb_read(written_q[i], rd);
			check_data($sformatf("wb_dat_o ram 0x%h", written_q[i]), rd,
				ram_model[ram_index(written_q[i])]);
		end
	endtask

	task automatic unmapped_access();
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] rd;
		// Region 7, low bits shared with a RAM word
		adr = {4'h7, written_q[0][27:0]};
		wb_read(adr, rd);
		check_data("wb_dat_o unmapped", rd, '0);
		wb_write(adr, $urandom, '1);
		wb_read(written_q[0], rd);
		check_data("wb_dat_o ram after unmapped", rd, ram_model[ram_index(written_q[0])]);
	endtask

	task automatic timer_one_shot();
		logic [DAT_W-1:0] rd;
		int               n;
		n = $urandom_range(60, 20);
		wb_write(timer_adr(1'b0, TMR_COMPARE), n, '1);
		wb_write(timer_adr(1'b0, TMR_COUNTER), '0, '1);
		wb_write(timer_adr(1'b0, TMR_CTRL), ctrl_word(1'b1, 1'b0, 1'b0), '1);
		wait_irq(0, n + 8);
		check_irq("irq_o", irq_o, 2'b01);
		// Stopped on the compare value
		wb_read(timer_adr(1'b0, TMR_COUNTER), rd);
		check_data("wb_dat_o timer0 counter", rd, n);
		wb_read(timer_adr(1'b0, TMR_CTRL), rd);
		check_data("wb_dat_o timer0 ctrl", rd, ctrl_word(1'b0, 1'b0, 1'b1));
		wb_write(timer_adr(1'b0, TMR_CTRL), ctrl_word(1'b0, 1'b0, 1'b1), '1);
		@(negedge clk_i);
		check_irq("irq_o", irq_o, 2'b00);
	endtask

	task automatic timer_auto_reload();
		int m;
		m = $urandom_range(50, 30);
		wb_write(timer_adr(1'b1, TMR_COMPARE), m, '1);
		wb_write(timer_adr(1'b1, TMR_COUNTER), '0, '1);
		wb_write(timer_adr(1'b1, TMR_CTRL), ctrl_word(1'b1, 1'b1, 1'b0), '1);
		repeat (3) begin
			wait_irq(1, m + 8);
			// Channel 0 stays quiet
			check_irq("irq_o", irq_o, 2'b10);
			wb_write(timer_adr(1'b1, TMR_CTRL), ctrl_word(1'b1, 1'b1, 1'b1), '1);
			@(negedge clk_i);
			check_irq("irq_o", irq_o, 2'b00);
		end
		// Stop channel 1
		wb_write(timer_adr(1'b1, TMR_CTRL), ctrl_word(1'b0, 1'b0, 1'b1), '1);
		@(negedge clk_i);
		check_irq("irq_o", irq_o, 2'b00);
	endtask

	task automatic pwm_duty_counts();
		logic [DAT_W-1:0] rd;
		int               period;
		int               duty [PWM_CHANNELS];
		int               high [PWM_CHANNELS];
		period = $urandom_range(24, 8);
		wb_write(pwm_adr(PWM_PERIOD_IDX), period, '1);
		for (int n = 0; n < PWM_CHANNELS; n++) begin
			// Some duties above the period
			duty[n] = $urandom_range(period + 4, 0);
			wb_write(pwm_adr(n + 1), duty[n], '1);
		end
		wb_read(pwm_adr(PWM_PERIOD_IDX), rd);
		check_data("wb_dat_o pwm period", rd, period);
		for (int n = 0; n < PWM_CHANNELS; n++) begin
			wb_read(pwm_adr(n + 1), rd);
			check_data($sformatf("wb_dat_o pwm duty %0d", n), rd, duty[n]);
		end
		// Past a wrap, new values active
		repeat (2 * period + 4) @(negedge clk_i);
		for (int n = 0; n < PWM_CHANNELS; n++)
			high[n] = 0;
		repeat (period) begin
			@(negedge clk_i);
			for (int n = 0; n < PWM_CHANNELS; n++) begin
				if (pwm_o[n])
					high[n]++;
			end
		end
		for (int n = 0; n < PWM_CHANNELS; n++)
			check_data($sformatf("pwm_o[%0d] high count", n), high[n],
				pwm_high_count(duty[n], period));
		// Zero period parks the outputs low
		wb_write(pwm_adr(PWM_PERIOD_IDX), '0, '1);
		repeat (2 * period + 4) @(negedge clk_i);
		repeat (period) begin
			@(negedge clk_i);
			check_pwm("pwm_o", pwm_o, '0);
		end
	endtask

	//--------------------
	// Main sequence
	//--------------------
	initial begin
		void'($urandom(32'hc590_c80f));
		reset_i    = 1'b1;
		wb_adr_i   = '0;
		wb_dat_i   = '0;
		wb_sel_i   = '0;
		wb_we_i    = 1'b0;
		wb_cyc_i   = 1'b0;
		wb_stb_i   = 1'b0;
		repeat (8) @(posedge clk_i);
		reset_i <= 1'b0;
		reset_values();
		ram_random();
		unmapped_access();
		timer_one_shot();
		timer_auto_reload();
		pwm_duty_counts();
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== verilog/periph_system.sv ====
//--------------------
// Peripheral subsystem top
// Decoder, block RAM, timer and PWM bank
//--------------------

module periph_system import soc_pkg::*; #(
	parameter int BRAM_ADR_W   = 10,
	parameter int PWM_CHANNELS = 8
) (
	input  logic                    clk_i,
	input  logic                    reset_i,
	// Master port
	input  logic [ADR_W-1:0]        wb_adr_i,
	input  logic [DAT_W-1:0]        wb_dat_i,
	input  logic [SEL_W-1:0]        wb_sel_i,
	input  logic                    wb_we_i,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	output logic [DAT_W-1:0]        wb_dat_o,
	output logic                    wb_ack_o,
	// Peripheral outputs
	output logic [1:0]              irq_o,
	output logic [PWM_CHANNELS-1:0] pwm_o
);

	//--------------------
	// Slave-side wires
	//--------------------
	logic [ADR_W-1:0] s_adr;
	logic [DAT_W-1:0] s_dat_w;
	logic [SEL_W-1:0] s_sel;
	logic             s_we;

	logic [DAT_W-1:0] bram_dat_r;
	logic             bram_ack;
	logic             bram_cyc;
	logic             bram_stb;

	logic [DAT_W-1:0] tmr_dat_r;
	logic             tmr_ack;
	logic             tmr_cyc;
	logic             tmr_stb;

	logic [DAT_W-1:0] pwm_dat_r;
	logic             pwm_ack;
	logic             pwm_cyc;
	logic             pwm_stb;

	// Interconnect
	wb_decoder decoder_i (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.m_adr_i      (wb_adr_i),
		.m_dat_i      (wb_dat_i),
		.m_sel_i      (wb_sel_i),
		.m_we_i       (wb_we_i),
		.m_cyc_i      (wb_cyc_i),
		.m_stb_i      (wb_stb_i),
		.m_dat_o      (wb_dat_o),
		.m_ack_o      (wb_ack_o),
		.s_adr_o      (s_adr),
		.s_dat_o      (s_dat_w),
		.s_sel_o      (s_sel),
		.s_we_o       (s_we),
		.s_bram_dat_i (bram_dat_r),
		.s_bram_ack_i (bram_ack),
		.s_bram_cyc_o (bram_cyc),
		.s_bram_stb_o (bram_stb),
		.s_tmr_dat_i  (tmr_dat_r),
		.s_tmr_ack_i  (tmr_ack),
		.s_tmr_cyc_o  (tmr_cyc),
		.s_tmr_stb_o  (tmr_stb),
		.s_pwm_dat_i  (pwm_dat_r),
		.s_pwm_ack_i  (pwm_ack),
		.s_pwm_cyc_o  (pwm_cyc),
		.s_pwm_stb_o  (pwm_stb)
	);

	// RAM at 0x0000_0000
	wb_bram #(
		.BRAM_ADR_W (BRAM_ADR_W)
	) bram_i (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.wb_adr_i (s_adr),
		.wb_dat_i (s_dat_w),
		.wb_sel_i (s_sel),
		.wb_we_i  (s_we),
		.wb_cyc_i (bram_cyc),
		.wb_stb_i (bram_stb),
		.wb_dat_o (bram_dat_r),
		.wb_ack_o (bram_ack)
	);

	// Timer at 0x3000_0000
	wb_timer timer_i (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.wb_adr_i (s_adr),
		.wb_dat_i (s_dat_w),
		.wb_we_i  (s_we),
		.wb_cyc_i (tmr_cyc),
		.wb_stb_i (tmr_stb),
		.wb_dat_o (tmr_dat_r),
		.wb_ack_o (tmr_ack),
		.irq_o    (irq_o)
	);

	// PWM bank at 0x4000_0000
	wb_pwm #(
		.PWM_CHANNELS (PWM_CHANNELS)
	) pwm_i (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.wb_adr_i (s_adr),
		.wb_dat_i (s_dat_w),
		.wb_we_i  (s_we),
		.wb_cyc_i (pwm_cyc),
		.wb_stb_i (pwm_stb),
		.wb_dat_o (pwm_dat_r),
		.wb_ack_o (pwm_ack),
		.pwm_o    (pwm_o)
	);

endmodule

// ==== verilog/wb_pwm.sv ====
//--------------------
// PWM bank, shared period and per-channel duty
// Shadow registers load at counter wrap
//--------------------

module wb_pwm import soc_pkg::*; #(
	parameter int PWM_CHANNELS = 8
) (
	input  logic                    clk_i,
	input  logic                    reset_i,
	input  logic [ADR_W-1:0]        wb_adr_i,
	input  logic [DAT_W-1:0]        wb_dat_i,
	input  logic                    wb_we_i,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	output logic [DAT_W-1:0]        wb_dat_o,
	output logic                    wb_ack_o,
	output logic [PWM_CHANNELS-1:0] pwm_o
);

	// Enough word index bits for period plus all duties
	localparam int IDX_W = $clog2(PWM_CHANNELS + 1);

	logic             req;
	logic             wr;
	logic [IDX_W-1:0] word_idx;
	logic [DAT_W-1:0] period_wr;
	logic [DAT_W-1:0] period_act;
	logic [DAT_W-1:0] duty_wr [PWM_CHANNELS];
	logic [DAT_W-1:0] duty_act [PWM_CHANNELS];
	logic [DAT_W-1:0] cnt_q;
	logic             wrap;
	logic [DAT_W-1:0] rd_data;

	assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign wr       = req && wb_we_i;
	assign word_idx = wb_adr_i[IDX_W+1:2];

	//--------------------
	// Written copies
	//--------------------
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			period_wr <= '0;
			for (int n = 0; n < PWM_CHANNELS; n++)
				duty_wr[n] <= '0;
		end else if (wr) begin
			if (word_idx == PWM_PERIOD_IDX)
				period_wr <= wb_dat_i;
			for (int n = 0; n < PWM_CHANNELS; n++) begin
				if (word_idx == n + 1)
					duty_wr[n] <= wb_dat_i;
			end
		end
	end

	//--------------------
	// Counter and active copies
	//--------------------
	// Zero period parks the counter, every cycle counts as a wrap
	assign wrap = (period_act == '0) || (cnt_q == period_act - 1'b1);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			cnt_q      <= '0;
			period_act <= '0;
			for (int n = 0; n < PWM_CHANNELS; n++)
				duty_act[n] <= '0;
		end else if (wrap) begin
			cnt_q      <= '0;
			period_act <= period_wr;
			for (int n = 0; n < PWM_CHANNELS; n++)
				duty_act[n] <= duty_wr[n];
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// Registered compares, low while the period is zero
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pwm_o <= '0;
		end else begin
			for (int n = 0; n < PWM_CHANNELS; n++)
				pwm_o[n] <= (period_act != '0) && (cnt_q < duty_act[n]);
		end
	end

	//--------------------
	// Bus readback
	//--------------------
	always_comb begin
		rd_data = '0;
		if (word_idx == PWM_PERIOD_IDX)
			rd_data = period_wr;
		for (int n = 0; n < PWM_CHANNELS; n++) begin
			if (word_idx == n + 1)
				rd_data = duty_wr[n];
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= req;
		end
	end

	always_ff @(posedge clk_i) begin
		if (req)
			wb_dat_o <= rd_data;
	end

endmodule

// ==== verilog/wb_timer.sv ====
//--------------------
// Two compare timers with interrupt flags
// One-shot and auto-reload modes
//--------------------

module wb_timer import soc_pkg::*; (
	input  logic             clk_i,
	input  logic             reset_i,
	input  logic [ADR_W-1:0] wb_adr_i,
	input  logic [DAT_W-1:0] wb_dat_i,
	input  logic             wb_we_i,
	input  logic             wb_cyc_i,
	input  logic             wb_stb_i,
	output logic [DAT_W-1:0] wb_dat_o,
	output logic             wb_ack_o,
	output logic [1:0]       irq_o
);

	logic             req;
	logic             wr;
	logic             ch;
	timer_reg_e       reg_idx;
	logic [1:0]       en_q;
	logic [1:0]       auto_q;
	logic [1:0]       flag_q;
	logic [DAT_W-1:0] compare_q [2];
	logic [DAT_W-1:0] count_q [2];
	logic [1:0]       match;
	logic [DAT_W-1:0] rd_data;

	//--------------------
	// Bus decode
	//--------------------
	assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign wr      = req && wb_we_i;
	// adr[4] picks the channel block
	assign ch      = wb_adr_i[4];
	assign reg_idx = timer_reg_e'(wb_adr_i[3:2]);

	// Compare hit on a running channel
	always_comb begin
		for (int c = 0; c < 2; c++)
			match[c] = en_q[c] && (count_q[c] == compare_q[c]);
	end

	//--------------------
	// Counters and registers
	//--------------------
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			en_q   <= '0;
			auto_q <= '0;
			flag_q <= '0;
			for (int c = 0; c < 2; c++) begin
				compare_q[c] <= '0;
				count_q[c]   <= '0;
			end
		end else begin
			for (int c = 0; c < 2; c++) begin
				if (match[c]) begin
					flag_q[c] <= 1'b1;
					// Reload, or stop holding the compare value
					if (auto_q[c])
						count_q[c] <= '0;
					else
						en_q[c] <= 1'b0;
				end else if (en_q[c]) begin
					count_q[c] <= count_q[c] + 1'b1;
				end
				// Bus writes win over counting
				if (wr && (ch == c[0])) begin
					case (reg_idx)
						TMR_CTRL: begin
							en_q[c]   <= wb_dat_i[CTRL_EN];
							auto_q[c] <= wb_dat_i[CTRL_AUTO];
							// Write one to clear, a fresh hit is kept
							if (wb_dat_i[CTRL_FLAG] && !match[c])
								flag_q[c] <= 1'b0;
						end
						TMR_COMPARE: compare_q[c] <= wb_dat_i;
						TMR_COUNTER: count_q[c] <= wb_dat_i;
						default: ;
					endcase
				end
			end
		end
	end

	assign irq_o = flag_q;

	//--------------------
	// Readback
	//--------------------
	always_comb begin
		rd_data = '0;
		case (reg_idx)
			TMR_CTRL: begin
				rd_data[CTRL_EN]   = en_q[ch];
				rd_data[CTRL_AUTO] = auto_q[ch];
				rd_data[CTRL_FLAG] = flag_q[ch];
			end
			TMR_COMPARE: rd_data = compare_q[ch];
			TMR_COUNTER: rd_data = count_q[ch];
			default:     rd_data = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= req;
		end
	end

	// Read data valid with ack
	always_ff @(posedge clk_i) begin
		if (req)
			wb_dat_o <= rd_data;
	end

endmodule

// ==== verilog/wb_bram.sv ====
//--------------------
// Single-port word RAM on a Wishbone slave port
// Byte-lane writes, registered read
//--------------------

module wb_bram import soc_pkg::*; #(
	parameter int BRAM_ADR_W = 10
) (
	input  logic             clk_i,
	input  logic             reset_i,
	input  logic [ADR_W-1:0] wb_adr_i,
	input  logic [DAT_W-1:0] wb_dat_i,
	input  logic [SEL_W-1:0] wb_sel_i,
	input  logic             wb_we_i,
	input  logic             wb_cyc_i,
	input  logic             wb_stb_i,
	output logic [DAT_W-1:0] wb_dat_o,
	output logic             wb_ack_o
);

	localparam int DEPTH = 2 ** BRAM_ADR_W;

	logic [DAT_W-1:0]      mem [DEPTH];
	logic [BRAM_ADR_W-1:0] word_adr;
	logic                  req;

	// Word index above the byte offset, wraps at the depth
	assign word_adr = wb_adr_i[BRAM_ADR_W+1:2];

	// New request only while own ack is low
	assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= req;
		end
	end

	// Array and read register
	always_ff @(posedge clk_i) begin
		if (req) begin
			if (wb_we_i) begin
				for (int b = 0; b < SEL_W; b++) begin
					if (wb_sel_i[b])
						mem[word_adr][8*b +: 8] <= wb_dat_i[8*b +: 8];
				end
			end
			// Old word, lines up with ack
			wb_dat_o <= mem[word_adr];
		end
	end

endmodule

// ==== verilog/wb_decoder.sv ====
//--------------------
// Wishbone decoder, one master to three slaves
// Read data and ack multiplexer
// Answers cycles to unmapped regions
//--------------------

module wb_decoder import soc_pkg::*; (
	input  logic             clk_i,
	input  logic             reset_i,
	// Master side
	input  logic [ADR_W-1:0] m_adr_i,
	input  logic [DAT_W-1:0] m_dat_i,
	input  logic [SEL_W-1:0] m_sel_i,
	input  logic             m_we_i,
	input  logic             m_cyc_i,
	input  logic             m_stb_i,
	output logic [DAT_W-1:0] m_dat_o,
	output logic             m_ack_o,
	// Shared slave signals
	output logic [ADR_W-1:0] s_adr_o,
	output logic [DAT_W-1:0] s_dat_o,
	output logic [SEL_W-1:0] s_sel_o,
	output logic             s_we_o,
	// Block RAM
	input  logic [DAT_W-1:0] s_bram_dat_i,
	input  logic             s_bram_ack_i,
	output logic             s_bram_cyc_o,
	output logic             s_bram_stb_o,
	// Timer
	input  logic [DAT_W-1:0] s_tmr_dat_i,
	input  logic             s_tmr_ack_i,
	output logic             s_tmr_cyc_o,
	output logic             s_tmr_stb_o,
	// PWM bank
	input  logic [DAT_W-1:0] s_pwm_dat_i,
	input  logic             s_pwm_ack_i,
	output logic             s_pwm_cyc_o,
	output logic             s_pwm_stb_o
);

	slave_e target;
	logic   none_ack_q;

	//--------------------
	// Region decode
	//--------------------
	always_comb begin
		case (m_adr_i[ADR_W-1 -: 4])
			REGION_BRAM:  target = SLV_BRAM;
			REGION_TIMER: target = SLV_TIMER;
			REGION_PWM:   target = SLV_PWM;
			default:      target = SLV_NONE;
		endcase
	end

	// Address, data, select and we go to every slave
	assign s_adr_o = m_adr_i;
	assign s_dat_o = m_dat_i;
	assign s_sel_o = m_sel_i;
	assign s_we_o  = m_we_i;

	// Strobe only the selected slave
	assign s_bram_cyc_o = m_cyc_i && (target == SLV_BRAM);
	assign s_bram_stb_o = m_stb_i && (target == SLV_BRAM);
	assign s_tmr_cyc_o  = m_cyc_i && (target == SLV_TIMER);
	assign s_tmr_stb_o  = m_stb_i && (target == SLV_TIMER);
	assign s_pwm_cyc_o  = m_cyc_i && (target == SLV_PWM);
	assign s_pwm_stb_o  = m_stb_i && (target == SLV_PWM);

	// One-cycle answer for unmapped space, keeps the bus from hanging
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			none_ack_q <= 1'b0;
		end else begin
			none_ack_q <= m_cyc_i && m_stb_i && (target == SLV_NONE) && !none_ack_q;
		end
	end

	//--------------------
	// Return path
	//--------------------
	always_comb begin
		case (target)
			SLV_BRAM: begin
				m_dat_o = s_bram_dat_i;
				m_ack_o = s_bram_ack_i;
			end
			SLV_TIMER: begin
				m_dat_o = s_tmr_dat_i;
				m_ack_o = s_tmr_ack_i;
			end
			SLV_PWM: begin
				m_dat_o = s_pwm_dat_i;
				m_ack_o = s_pwm_ack_i;
			end
			default: begin
				// Unmapped reads return zero
				m_dat_o = '0;
				m_ack_o = none_ack_q;
			end
		endcase
	end

endmodule

// ==== verilog/soc_pkg.sv ====
//--------------------
// Shared bus widths, address map and
// register encodings for the peripheral subsystem
//--------------------

package soc_pkg;

	// Bus widths
	localparam int ADR_W = 32;
	localparam int DAT_W = 32;
	localparam int SEL_W = 4;

	// Decoder target
	typedef enum logic [1:0] {
		SLV_BRAM,
		SLV_TIMER,
		SLV_PWM,
		SLV_NONE
	} slave_e;

	// Address map, values of adr[31:28]
	localparam logic [3:0] REGION_BRAM  = 4'h0;
	localparam logic [3:0] REGION_TIMER = 4'h3;
	localparam logic [3:0] REGION_PWM   = 4'h4;

	// Timer word index inside a channel block, adr[3:2]
	typedef enum logic [1:0] {
		TMR_CTRL,
		TMR_COMPARE,
		TMR_COUNTER
	} timer_reg_e;

	// Timer control bits
	localparam int CTRL_EN   = 0;
	localparam int CTRL_AUTO = 1;
	localparam int CTRL_FLAG = 2;

	// PWM period word, duty n sits at word n+1
	localparam int PWM_PERIOD_IDX = 0;

endpackage
